//--- source/turfio_ctrl_pkg.sv
package turfio_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // wishbone geometry
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned WB_ADR_BITS = 11;
    localparam int unsigned WB_DAT_BITS = 32;
    localparam int unsigned WB_SEL_BITS = 4;

    // bits 7:6 pick the clock domain, only domain 0 is backed by logic
    localparam logic [WB_ADR_BITS-1:0] DOMAIN_MASK     = 11'h0C0;
    localparam logic [WB_ADR_BITS-1:0] CONTROL_REG_ADR = 11'h000;

    //////////////////////////////////////////////////////////////////////
    // fine phase shift
    //////////////////////////////////////////////////////////////////////

    // 12x multiplier times 56 steps per VCO period
    localparam int unsigned PS_STEPS = 672;
    localparam int unsigned PS_BITS  = 10;
    localparam logic [PS_BITS-1:0] PS_LAST = PS_BITS'(PS_STEPS - 1);

    //////////////////////////////////////////////////////////////////////
    // control register layout
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned CIN_RST_BIT       = 0;
    localparam int unsigned DIS_VTC_BIT       = 1;
    localparam int unsigned IDCTRL_RST_BIT    = 2;
    localparam int unsigned IDCTRL_RDY_BIT    = 3;
    localparam int unsigned MMCM_RST_BIT      = 4;
    localparam int unsigned MMCM_LOCKED_BIT   = 5;
    localparam int unsigned TRAIN_LSB         = 6;
    localparam int unsigned BITSLIP_RST_BIT   = 8;
    localparam int unsigned BITSLIP_BIT       = 9;
    localparam int unsigned LOCK_RST_BIT      = 10;
    localparam int unsigned LOCK_REQ_BIT      = 11;
    localparam int unsigned LOCK_STATUS_BIT   = 12;
    localparam int unsigned PLL_RST_BIT       = 13;
    localparam int unsigned PLL_LOCKED_BIT    = 14;
    localparam int unsigned ALIGN_ERR_BIT     = 15;
    localparam int unsigned PS_TARGET_LSB     = 16;
    localparam int unsigned PS_INCOMPLETE_BIT = 31;

    // one captured bus access
    typedef struct packed {
        logic [WB_ADR_BITS-1:0] adr;
        logic [WB_DAT_BITS-1:0] dat;
        logic [WB_SEL_BITS-1:0] sel;
        logic                   we;
    } wb_req_t;

    typedef struct packed {
        logic       cin_rst;
        logic       dis_vtc;
        logic       idelayctrl_rst;
        logic       mmcm_rst;
        logic       pll_rst;
        logic [1:0] train_en;
    } ctrl_levels_t;

    // single-cycle requests
    typedef struct packed {
        logic bitslip_rst;
        logic bitslip;
        logic lock_rst;
        logic lock_req;
    } ctrl_pulses_t;

    typedef struct packed {
        logic idelayctrl_rdy;
        logic mmcm_locked;
        logic lock_status;
        logic pll_locked;
        logic align_err;
    } status_t;

endpackage

//--- source/wb_slave_port.sv
`timescale 1ns/1ps

module wb_slave_port
    import turfio_ctrl_pkg::*;
(
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [WB_ADR_BITS-1:0] wb_adr_i,
    input  logic [WB_DAT_BITS-1:0] wb_dat_i,
    input  logic [WB_SEL_BITS-1:0] wb_sel_i,
    input  logic [WB_DAT_BITS-1:0] rd_word_i,
    output wb_req_t                req_o,
    output logic                   wr_stb_o,
    output logic [WB_DAT_BITS-1:0] wb_dat_o,
    output logic                   wb_ack_o
);

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } state_t;

    state_t                 state_q;
    logic                   wr_stb_q;
    wb_req_t                req_q;
    logic [WB_DAT_BITS-1:0] dat_q;

    logic                   start;
    logic                   dom0;
    logic [WB_DAT_BITS-1:0] merged_dat;

    // a new access is only taken from idle
    assign start = (state_q == ST_IDLE) && wb_cyc_i && wb_stb_i;
    assign dom0  = (wb_adr_i & DOMAIN_MASK) == '0;

    // unselected lanes keep what the last access left there
    always_comb begin
        merged_dat = req_q.dat;
        for (int i = 0; i < WB_SEL_BITS; i++) begin
            if (wb_sel_i[i]) begin
                merged_dat[8*i +: 8] = wb_dat_i[8*i +: 8];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q  <= ST_IDLE;
            wr_stb_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (start) state_q <= ST_ACK;
                default: state_q <= ST_IDLE;
            endcase
            wr_stb_q <= start && wb_we_i && dom0;
        end
    end

    // request and read data are captured together
    always_ff @(posedge wb_clk_i) begin
        if (start) begin
            req_q.adr <= wb_adr_i;
            req_q.dat <= merged_dat;
            req_q.sel <= wb_sel_i;
            req_q.we  <= wb_we_i;
            // other domains are not implemented here
            dat_q     <= dom0 ? rd_word_i : '1;
        end
    end

    assign req_o    = req_q;
    assign wr_stb_o = wr_stb_q;
    assign wb_dat_o = dat_q;
    assign wb_ack_o = (state_q == ST_ACK);

endmodule

//--- source/control_regfile.sv
`timescale 1ns/1ps

module control_regfile
    import turfio_ctrl_pkg::*;
(
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  wb_req_t                req_i,
    input  logic                   wr_stb_i,
    input  status_t                status_i,
    input  logic                   ps_incomplete_i,
    output ctrl_levels_t           levels_o,
    output ctrl_pulses_t           pulses_o,
    output logic [PS_BITS-1:0]     ps_target_o,
    output logic [WB_DAT_BITS-1:0] rd_word_o
);

    ctrl_levels_t           levels_q;
    ctrl_pulses_t           pulses_q;
    logic [PS_BITS-1:0]     target_q;
    logic                   target_wr_q;
    status_t                status_meta_q;
    status_t                status_sync_q;

    logic                   reg_wr;
    logic                   target_wr;
    logic [WB_DAT_BITS-1:0] wdat;

    assign reg_wr    = wr_stb_i && (req_i.adr == CONTROL_REG_ADR);
    // target is 10 bits across lanes 2 and 3, so both must be present
    assign target_wr = reg_wr && req_i.sel[2] && req_i.sel[3];
    assign wdat      = req_i.dat;

    //////////////////////////////////////////////////////////////////////
    // writable fields
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            levels_q         <= '0;
            // ACLK PLLs come up held in reset
            levels_q.pll_rst <= 1'b1;
            pulses_q         <= '0;
            target_q         <= '0;
            target_wr_q      <= 1'b0;
        end else begin
            // request bits only live for one cycle
            pulses_q    <= '0;
            target_wr_q <= target_wr;
            if (reg_wr && req_i.sel[0]) begin
                levels_q.cin_rst        <= wdat[CIN_RST_BIT];
                levels_q.dis_vtc        <= wdat[DIS_VTC_BIT];
                levels_q.idelayctrl_rst <= wdat[IDCTRL_RST_BIT];
                levels_q.mmcm_rst       <= wdat[MMCM_RST_BIT];
                levels_q.train_en       <= wdat[TRAIN_LSB +: 2];
            end
            if (reg_wr && req_i.sel[1]) begin
                pulses_q.bitslip_rst <= wdat[BITSLIP_RST_BIT];
                pulses_q.bitslip     <= wdat[BITSLIP_BIT];
                pulses_q.lock_rst    <= wdat[LOCK_RST_BIT];
                pulses_q.lock_req    <= wdat[LOCK_REQ_BIT];
                levels_q.pll_rst     <= wdat[PLL_RST_BIT];
            end
            if (target_wr) begin
                target_q <= wdat[PS_TARGET_LSB +: PS_BITS];
            end
        end
    end

    // two-flop synchronizers on the asynchronous status inputs
    always_ff @(posedge wb_clk_i) begin
        status_meta_q <= status_i;
        status_sync_q <= status_meta_q;
    end

    //////////////////////////////////////////////////////////////////////
    // readback
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_word_o                          = '0;
        rd_word_o[CIN_RST_BIT]             = levels_q.cin_rst;
        rd_word_o[DIS_VTC_BIT]             = levels_q.dis_vtc;
        rd_word_o[IDCTRL_RST_BIT]          = levels_q.idelayctrl_rst;
        rd_word_o[IDCTRL_RDY_BIT]          = status_sync_q.idelayctrl_rdy;
        rd_word_o[MMCM_RST_BIT]            = levels_q.mmcm_rst;
        rd_word_o[MMCM_LOCKED_BIT]         = status_sync_q.mmcm_locked;
        rd_word_o[TRAIN_LSB +: 2]          = levels_q.train_en;
        rd_word_o[BITSLIP_RST_BIT]         = pulses_q.bitslip_rst;
        rd_word_o[BITSLIP_BIT]             = pulses_q.bitslip;
        rd_word_o[LOCK_RST_BIT]            = pulses_q.lock_rst;
        rd_word_o[LOCK_REQ_BIT]            = pulses_q.lock_req;
        rd_word_o[LOCK_STATUS_BIT]         = status_sync_q.lock_status;
        rd_word_o[PLL_RST_BIT]             = levels_q.pll_rst;
        rd_word_o[PLL_LOCKED_BIT]          = status_sync_q.pll_locked;
        rd_word_o[ALIGN_ERR_BIT]           = status_sync_q.align_err;
        rd_word_o[PS_TARGET_LSB +: PS_BITS] = target_q;
        // stepper flag lags a target write by one cycle, cover that gap
        rd_word_o[PS_INCOMPLETE_BIT]       = ps_incomplete_i || target_wr_q;
    end

    assign levels_o    = levels_q;
    assign pulses_o    = pulses_q;
    assign ps_target_o = target_q;

endmodule

//--- source/phase_shift_stepper.sv
`timescale 1ns/1ps

module phase_shift_stepper
    import turfio_ctrl_pkg::*;
(
    input  logic               wb_clk_i,
    input  logic               wb_rst_i,
    input  logic [PS_BITS-1:0] target_i,
    input  logic               ps_done_i,
    output logic               ps_en_o,
    output logic               incomplete_o
);

    logic [PS_BITS-1:0] current_q;
    logic               busy_q;
    logic               ps_en_q;
    logic               incomplete_q;

    logic               step;
    logic [PS_BITS-1:0] current_next;

    // only one increment outstanding at the MMCM at a time
    assign step = (target_i != current_q) && !busy_q;

    // phase wraps after one full VCO period
    assign current_next = (current_q == PS_LAST) ? '0 : current_q + 1'b1;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            current_q    <= '0;
            busy_q       <= 1'b0;
            ps_en_q      <= 1'b0;
            incomplete_q <= 1'b0;
        end else begin
            ps_en_q <= step;
            if (step) begin
                current_q <= current_next;
                busy_q    <= 1'b1;
            end else if (ps_done_i) begin
                busy_q <= 1'b0;
            end
            incomplete_q <= (target_i != current_q) || busy_q;
        end
    end

    assign ps_en_o      = ps_en_q;
    assign incomplete_o = incomplete_q;

endmodule

//--- source/turfio_ctrl_top.sv
`timescale 1ns/1ps

module turfio_ctrl_top
    import turfio_ctrl_pkg::*;
(
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [WB_ADR_BITS-1:0] wb_adr_i,
    input  logic [WB_DAT_BITS-1:0] wb_dat_i,
    input  logic [WB_SEL_BITS-1:0] wb_sel_i,
    output logic [WB_DAT_BITS-1:0] wb_dat_o,
    output logic                   wb_ack_o,

    // status from the clocking and capture logic
    input  logic                   idelayctrl_rdy_i,
    input  logic                   mmcm_locked_i,
    input  logic                   lock_status_i,
    input  logic                   aclk_locked_i,
    input  logic                   ifclk_alignerr_i,

    // MMCM fine phase shift
    input  logic                   ps_done_i,
    output logic                   ps_en_o,

    output logic                   cin_rst_o,
    output logic                   en_vtc_o,
    output logic                   idelayctrl_rst_o,
    output logic                   mmcm_rst_o,
    output logic                   aclk_reset_o,
    output logic [1:0]             train_en_o,
    output logic                   bitslip_rst_o,
    output logic                   bitslip_o,
    output logic                   lock_rst_o,
    output logic                   lock_req_o
);

    wb_req_t                req;
    logic                   wr_stb;
    logic [WB_DAT_BITS-1:0] rd_word;
    status_t                status;
    ctrl_levels_t           levels;
    ctrl_pulses_t           pulses;
    logic [PS_BITS-1:0]     ps_target;
    logic                   ps_incomplete;

    assign status.idelayctrl_rdy = idelayctrl_rdy_i;
    assign status.mmcm_locked    = mmcm_locked_i;
    assign status.lock_status    = lock_status_i;
    assign status.pll_locked     = aclk_locked_i;
    assign status.align_err      = ifclk_alignerr_i;

    wb_slave_port u_wb_slave_port (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .rd_word_i (rd_word),
        .req_o     (req),
        .wr_stb_o  (wr_stb),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o)
    );

    control_regfile u_control_regfile (
        .wb_clk_i        (wb_clk_i),
        .wb_rst_i        (wb_rst_i),
        .req_i           (req),
        .wr_stb_i        (wr_stb),
        .status_i        (status),
        .ps_incomplete_i (ps_incomplete),
        .levels_o        (levels),
        .pulses_o        (pulses),
        .ps_target_o     (ps_target),
        .rd_word_o       (rd_word)
    );

    phase_shift_stepper u_phase_shift_stepper (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .target_i     (ps_target),
        .ps_done_i    (ps_done_i),
        .ps_en_o      (ps_en_o),
        .incomplete_o (ps_incomplete)
    );

    assign cin_rst_o        = levels.cin_rst;
    // register holds the disable, the pin is the enable
    assign en_vtc_o         = !levels.dis_vtc;
    assign idelayctrl_rst_o = levels.idelayctrl_rst;
    assign mmcm_rst_o       = levels.mmcm_rst;
    assign aclk_reset_o     = levels.pll_rst;
    assign train_en_o       = levels.train_en;
    assign bitslip_rst_o    = pulses.bitslip_rst;
    assign bitslip_o        = pulses.bitslip;
    assign lock_rst_o       = pulses.lock_rst;
    assign lock_req_o       = pulses.lock_req;

endmodule

//--- test/tb_turfio_ctrl.sv
`timescale 1ns/1ps

module tb_turfio_ctrl
    import turfio_ctrl_pkg::*;
();

    // writable level bits are 0, 1, 2, 4, 7:6 and 13
    localparam logic [31:0] LEVEL_MASK = 32'h0000_20D7;
    localparam int unsigned PS_SHIFTS  = 3;
    // 3 shifts of up to 671 steps at 6 cycles each, plus bus traffic and margin
    localparam int unsigned TIMEOUT_CYCLES = 20000;

    logic                   wb_clk_i;
    logic                   wb_rst_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_we_i;
    logic [WB_ADR_BITS-1:0] wb_adr_i;
    logic [WB_DAT_BITS-1:0] wb_dat_i;
    logic [WB_SEL_BITS-1:0] wb_sel_i;
    logic [WB_DAT_BITS-1:0] wb_dat_o;
    logic                   wb_ack_o;
    logic                   idelayctrl_rdy_i;
    logic                   mmcm_locked_i;
    logic                   lock_status_i;
    logic                   aclk_locked_i;
    logic                   ifclk_alignerr_i;
    logic                   ps_done_i;
    logic                   ps_en_o;
    logic                   cin_rst_o;
    logic                   en_vtc_o;
    logic                   idelayctrl_rst_o;
    logic                   mmcm_rst_o;
    logic                   aclk_reset_o;
    logic [1:0]             train_en_o;
    logic                   bitslip_rst_o;
    logic                   bitslip_o;
    logic                   lock_rst_o;
    logic                   lock_req_o;

    // reference model of the register
    logic [31:0]            m_ctrl;
    logic [PS_BITS-1:0]     m_target;
    logic [4:0]             m_status;
    logic                   m_busy;

    int unsigned            errors;
    int unsigned            checks;
    int unsigned            ps_count;
    int unsigned            cycles;
    logic [31:0]            rd_got;
    logic [31:0]            rd_exp;
    event                   rd_done;

    turfio_ctrl_top dut_i (.*);

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // reference and checking
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] expected_word(input logic [31:0] ctrl,
                                                  input logic [PS_BITS-1:0] target,
                                                  input logic [4:0] status,
                                                  input logic busy);
        logic [31:0] w;
        w = ctrl & LEVEL_MASK;
        w[IDCTRL_RDY_BIT]            = status[0];
        w[MMCM_LOCKED_BIT]           = status[1];
        w[LOCK_STATUS_BIT]           = status[2];
        w[PLL_LOCKED_BIT]            = status[3];
        w[ALIGN_ERR_BIT]             = status[4];
        w[PS_TARGET_LSB +: PS_BITS]  = target;
        w[PS_INCOMPLETE_BIT]         = busy;
        return w;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_pins(input logic [3:0] pulses);
        compare("level pins",
                {aclk_reset_o, train_en_o, mmcm_rst_o, idelayctrl_rst_o, !en_vtc_o, cin_rst_o},
                {m_ctrl[13], m_ctrl[7:6], m_ctrl[4], m_ctrl[2], m_ctrl[1], m_ctrl[0]});
        compare("pulse pins", {lock_req_o, lock_rst_o, bitslip_o, bitslip_rst_o}, pulses);
    endtask

    always @(rd_done) begin
        compare("wb_dat_o", rd_got, rd_exp);
    end

    // each ps_en_o pulse lasts one cycle
    always @(negedge wb_clk_i) begin
        if (ps_en_o === 1'b1) begin
            ps_count++;
        end
    end

    // MMCM answers every step request after 1 to 4 cycles
    initial begin
        int unsigned lag;
        forever begin
            @(negedge wb_clk_i);
            if (ps_en_o === 1'b1) begin
                lag = $urandom_range(4, 1);
                repeat (lag) @(negedge wb_clk_i);
                ps_done_i = 1'b1;
                @(negedge wb_clk_i);
                ps_done_i = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic bus_access(input logic we, input logic [WB_ADR_BITS-1:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel,
                              output logic [31:0] rdata);
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        @(negedge wb_clk_i);
        while (wb_ack_o !== 1'b1) @(negedge wb_clk_i);
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic write_reg(input logic [WB_ADR_BITS-1:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        logic [3:0]  pulses;
        bus_access(1'b1, adr, dat, sel, unused);
        pulses = '0;
        if (adr == CONTROL_REG_ADR) begin
            if (sel[0]) m_ctrl[7:0] = dat[7:0];
            if (sel[1]) m_ctrl[15:8] = dat[15:8];
            if (sel[1]) pulses = dat[11:8];
            if (sel[2] && sel[3]) m_target = dat[PS_TARGET_LSB +: PS_BITS];
        end
        // first cycle after ack carries the pulses
        @(negedge wb_clk_i);
        compare("wb_ack_o", wb_ack_o, 32'h0);
        check_pins(pulses);
        @(negedge wb_clk_i);
        check_pins(4'b0000);
    endtask

    task automatic read_reg(input logic [WB_ADR_BITS-1:0] adr);
        logic [31:0] data;
        bus_access(1'b0, adr, '0, 4'hF, data);
        rd_got = data;
        if ((adr & DOMAIN_MASK) != '0) rd_exp = '1;
        else rd_exp = expected_word(m_ctrl, m_target, m_status, m_busy);
        -> rd_done;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge wb_clk_i);
            cycles++;
        end
        $display("timeout: test did not complete within %0d clock cycles", TIMEOUT_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int unsigned        steps;
        int unsigned        start;
        logic [PS_BITS-1:0] target;
        logic [31:0]        data;
        void'($urandom(32'h151b_d13e));
        errors = 0;
        checks = 0;
        ps_count = 0;
        wb_rst_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        {ifclk_alignerr_i, aclk_locked_i, lock_status_i, mmcm_locked_i, idelayctrl_rdy_i} = '0;
        ps_done_i = 1'b0;
        m_ctrl    = 32'h0000_2000;
        m_target  = '0;
        m_status  = '0;
        m_busy    = 1'b0;
        repeat (3) @(negedge wb_clk_i);
        wb_rst_i = 1'b0;

        // reset values
        @(negedge wb_clk_i);
        compare("wb_ack_o", wb_ack_o, 32'h0);
        compare("ps_en_o", ps_en_o, 32'h0);
        check_pins(4'b0000);
        read_reg(CONTROL_REG_ADR);

        // random level writes that keep the target field
        for (int i = 0; i < 24; i++) begin
            data = $urandom;
            data[PS_TARGET_LSB +: PS_BITS] = m_target;
            write_reg(CONTROL_REG_ADR, data, 4'($urandom));
            read_reg(CONTROL_REG_ADR);
        end

        // each request bit alone, then all four
        for (int i = 0; i < 4; i++) begin
            write_reg(CONTROL_REG_ADR, (32'h100 << i) | (m_ctrl & 32'h2000), 4'b0010);
        end
        write_reg(CONTROL_REG_ADR, 32'h0F00 | (m_ctrl & 32'h2000), 4'b0010);
        read_reg(CONTROL_REG_ADR);

        // status inputs through the synchronizers
        for (int i = 0; i < 6; i++) begin
            @(negedge wb_clk_i);
            m_status = 5'($urandom);
            {ifclk_alignerr_i, aclk_locked_i, lock_status_i,
             mmcm_locked_i, idelayctrl_rdy_i} = m_status;
            repeat (3) @(negedge wb_clk_i);
            read_reg(CONTROL_REG_ADR);
        end

        // fine phase shifts with the middle one wrapping past 671
        for (int n = 0; n < PS_SHIFTS; n++) begin
            do begin
                target = PS_BITS'($urandom_range(PS_STEPS - 1));
            end while (target == m_target || (n == 1 && target > m_target));
            steps = (target + PS_STEPS - m_target) % PS_STEPS;
            start = ps_count;
            write_reg(CONTROL_REG_ADR, 32'(target) << PS_TARGET_LSB, 4'b1100);
            m_busy = 1'b1;
            read_reg(CONTROL_REG_ADR);
            while (ps_count - start < steps) @(negedge wb_clk_i);
            // poll until the DUT reports the shift finished
            do begin
                bus_access(1'b0, CONTROL_REG_ADR, '0, 4'hF, data);
            end while (data[PS_INCOMPLETE_BIT] === 1'b1);
            m_busy = 1'b0;
            read_reg(CONTROL_REG_ADR);
            compare("ps_en_o pulse count", ps_count - start, steps);
        end

        // other domains
        read_reg(11'h040);
        read_reg(11'h080);
        write_reg(11'h040, $urandom, 4'hF);
        write_reg(11'h080, $urandom, 4'hF);
        read_reg(CONTROL_REG_ADR);

        repeat (2) @(negedge wb_clk_i);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- src.f
source/turfio_ctrl_pkg.sv
source/wb_slave_port.sv
source/control_regfile.sv
source/phase_shift_stepper.sv
source/turfio_ctrl_top.sv
test/tb_turfio_ctrl.sv

//--- Bender.yml
package:
  name: turfio_ctrl

sources:
  - source/turfio_ctrl_pkg.sv
  - source/wb_slave_port.sv
  - source/control_regfile.sv
  - source/phase_shift_stepper.sv
  - source/turfio_ctrl_top.sv
  - target: test
    files:
      - test/tb_turfio_ctrl.sv
